//--- src/coreFrontEndPkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared widths, opcodes, via codes and microword layout for the core
// front end. Every block imports it with a wildcard import
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package coreFrontEndPkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths

    localparam int unsigned dataWidth = 8;       // Data bus and register byte
    localparam int unsigned wordWidth = 16;      // Address word (MAR, PC, vector)

    ////////////////////////////////////////////////////////////////////////////
    // Opcodes with a fixed mode

    localparam logic [7:0] opNop = 8'hEA;        // Reset and interrupt-latch value
    localparam logic [7:0] opWai = 8'hCB;        // Wait for interrupt
    localparam logic [7:0] opPhw = 8'hF4;        // Push word from {OP2, OP1}
    localparam logic [7:0] opPhr = 8'h62;        // Push relative, word from MAR

    // Prefix opcodes 8B, 9B, AB, BB share these bits
    localparam logic [1:0] pfxTop = 2'b10;       // IR[7:6]
    localparam logic [3:0] pfxLow = 4'hB;        // IR[3:0]

    ////////////////////////////////////////////////////////////////////////////
    // Sequencer via codes, 00 means instruction still in progress

    localparam logic [1:0] viaFetch1   = 2'b01;  // Plain opcode fetch
    localparam logic [1:0] viaLatchInt = 2'b10;  // Interrupt latch, vector load
    localparam logic [1:0] viaFetch3   = 2'b11;  // Fetch unless Int pending

    localparam int unsigned ioRead = 1;          // Read bit of ioOp

    localparam logic [1:0] uCntlSelBa = 2'b01;   // uCntl value selecting branchField

    // Instruction mode, registered with IR
    typedef enum logic [2:0] {
        modeVal = 3'd0,                          // Ordinary instruction
        modePfx = 3'd4,                          // Prefix byte
        modePhr = 3'd5,                          // PHR
        modePhw = 3'd6,                          // PHW
        modeWai = 3'd7                           // WAI
    } modeT;

    // Data-op field read as input demux controls
    typedef struct packed {
        logic ldIr;                              // Load IR from branch field
        logic ldOp1;                             // Load OP1
        logic ldOp2;                             // Load OP2
        logic signFill;                          // OP2 gets sign of source byte
    } dataInOpT;

    // Same field read as output mux selects
    typedef struct packed {
        logic selP;                              // Status word
        logic selLo;                             // Low byte of word source
        logic selHi;                             // High byte of word source
        logic selAlu;                            // ALU result
    } dataOutOpT;

    typedef union packed {
        dataInOpT  diView;
        dataOutOpT doView;
    } dataOpU;

    // Registered microword, fields as seen by the front end
    typedef struct packed {
        logic [dataWidth-1:0] branchField;       // Branch address or immediate byte
        logic [1:0]           uCntl;             // 01 = selBa, bit 0 also VP value
        logic [1:0]           ioOp;              // Memory cycle type
        dataOpU               dataOp;            // DI or DO control, shared bits
        logic [2:0]           regWe;             // Register write enables
        logic                 isr;               // Update VP this cycle
    } uWordT;

endpackage

`default_nettype wire

//--- src/microwordLatch.sv
////////////////////////////////////////////////////////////////////////////
// Pipeline register between the external sequencer and the front end.
// Holds the microword while the core is stalled
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module microwordLatch
    import coreFrontEndPkg::*;
(
    input  logic  Clk,
    input  logic  reset,
    input  logic  Rdy,       // Advance enable from cycle control
    input  uWordT uWord,     // Microword from the sequencer ROM
    output uWordT uPl        // Registered microword
);

    ////////////////////////////////////////////////////////////////////////////
    // Latch
    //
    // Loads during reset as well, so the word presented while reset is
    // high becomes the first microword. No clear value of its own

    always_ff @(posedge Clk)
    begin
        if (Rdy || reset)
        begin
            uPl <= uWord;    // Fields take effect from the next cycle
        end
    end

    // Stall behaviour
    // With Rdy low the previous word stays, so every strobe decoded from
    // uPl repeats until the wait ends

endmodule

`default_nettype wire

//--- src/cycleControl.sv
////////////////////////////////////////////////////////////////////////////
// Via decode, ready generation and register clock enables. Also holds
// the vector-pull flag driven by the microword isr bit
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module cycleControl
    import coreFrontEndPkg::*;
(
    input  logic       Clk,
    input  logic       reset,
    input  uWordT      uPl,      // Registered microword
    input  logic [1:0] via,      // Sequencer via code
    input  logic       Wait,     // External memory wait
    input  logic       Int,      // Pending interrupt
    input  logic       Valid,    // ALU result valid
    output logic       Done,     // Instruction complete
    output logic       SC,       // Single cycle fetch
    output logic       Rdy,      // Internal clock enable
    output logic       LE_Int,   // Interrupt latch enable
    output logic       VP,       // Vector pull
    output logic       ceIr,     // IR clock enable
    output logic       ceOp1,    // OP1 clock enable
    output logic       ceOp2     // OP2 clock enable
);

    logic regWrite;              // Any register write this cycle
    logic selBa;                 // Branch field is the data source
    logic fetch;                 // Via asks for an opcode fetch

    ////////////////////////////////////////////////////////////////////////////
    // Status strobes

    assign Done   = (via != 2'b00);
    assign SC     = (via == viaFetch3);
    assign LE_Int = (via == viaLatchInt);

    // Ready
    // At end of instruction a pending register write has to wait for the
    // ALU, otherwise only the external wait matters
    assign regWrite = |uPl.regWe;
    assign Rdy      = ~Wait & ~(Done & regWrite & ~Valid);

    ////////////////////////////////////////////////////////////////////////////
    // Clock enables

    assign selBa = (uPl.uCntl == uCntlSelBa);
    assign fetch = (via == viaFetch1) || ((via == viaFetch3) && !Int);

    assign ceIr  = Rdy & (fetch | (selBa & uPl.dataOp.diView.ldIr));
    // IR wins over the operands when both would load
    assign ceOp1 = Rdy & uPl.dataOp.diView.ldOp1 & uPl.ioOp[ioRead] & ~ceIr;
    assign ceOp2 = Rdy & uPl.dataOp.diView.ldOp2 & uPl.ioOp[ioRead] & ~ceIr;

    // Vector pull flag, not held off by Rdy
    always_ff @(posedge Clk)
    begin
        if (reset)
        begin
            VP <= 1'b0;
        end
        else if (uPl.isr)
        begin
            VP <= uPl.uCntl[0];  // Set on entry, cleared on exit
        end
    end

endmodule

`default_nettype wire

//--- src/instrRegister.sv
////////////////////////////////////////////////////////////////////////////
// Instruction register with a fixed mode decode and the four prefix
// registers. Loads from DI or the microword branch field
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module instrRegister
    import coreFrontEndPkg::*;
(
    input  logic                 Clk,
    input  logic                 reset,
    input  logic                 ceIr,         // Load enable
    input  logic                 latchInt,     // Via 10, force NOP
    input  logic                 selBa,        // Take branchField instead of DI
    input  logic [dataWidth-1:0] branchField,
    input  logic [dataWidth-1:0] DI,
    output logic [dataWidth-1:0] IR,
    output modeT                 Mode,         // Mode of the opcode in IR
    output logic                 IND,          // Indirect override
    output logic                 SIZ,          // 16-bit size override
    output logic                 OAX,          // Destination becomes X
    output logic                 OAY           // Destination becomes Y
);

    logic [dataWidth-1:0] irNext;

    // Fixed opcode table replacing the decode ROM
    function automatic modeT decodeMode(input logic [dataWidth-1:0] op);
        modeT m;
        m = modeVal;
        if ((op[7:6] == pfxTop) && (op[3:0] == pfxLow))
            m = modePfx;
        else if (op == opWai)
            m = modeWai;
        else if (op == opPhw)
            m = modePhw;
        else if (op == opPhr)
            m = modePhr;
        return m;
    endfunction

    assign irNext = selBa ? branchField : DI;

    ////////////////////////////////////////////////////////////////////////////
    // Opcode and mode

    always_ff @(posedge Clk)
    begin
        if (reset || latchInt)
        begin
            IR   <= opNop;               // NOP decodes as modeVal
            Mode <= modeVal;
        end
        else if (ceIr)
        begin
            IR   <= irNext;
            Mode <= decodeMode(irNext);  // Mode tracks IR cycle for cycle
        end
    end

    // Prefixes, taken from the outgoing IR and Mode at the next load
    always_ff @(posedge Clk)
    begin
        if (reset)
        begin
            {IND, SIZ, OAX, OAY} <= 4'b0000;
        end
        else if (ceIr)
        begin
            if (Mode == modePfx)
            begin
                IND <= IND | (IR[5:4] == 2'b11);   // BB, sticky
                SIZ <= SIZ | (IR[5:4] == 2'b10);   // AB, sticky
                OAX <= (IR[5:4] == 2'b01);         // 9B, one prefix only
                OAY <= (IR[5:4] == 2'b00);         // 8B, one prefix only
            end
            else
            begin
                {IND, SIZ, OAX, OAY} <= 4'b0000;   // Plain opcode ends the chain
            end
        end
    end

endmodule

`default_nettype wire

//--- src/operandRegisters.sv
////////////////////////////////////////////////////////////////////////////
// OP1 and OP2 operand bytes. Vector load on reset and interrupt latch,
// otherwise loaded from the selected source byte
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module operandRegisters
    import coreFrontEndPkg::*;
(
    input  logic                 Clk,
    input  logic                 reset,
    input  logic                 latchInt,   // Via 10
    input  logic                 ceOp1,
    input  logic                 ceOp2,
    input  logic                 signFill,   // OP2 takes sign byte
    input  logic [dataWidth-1:0] opDi,       // DI or branch field
    input  logic [wordWidth-1:0] Vector,     // Interrupt vector
    output logic [dataWidth-1:0] OP1,
    output logic [dataWidth-1:0] OP2
);

    // Low operand byte
    always_ff @(posedge Clk)
    begin
        if (reset || latchInt)
            OP1 <= Vector[dataWidth-1:0];
        else if (ceOp1)
            OP1 <= opDi;
    end

    // High operand byte, optionally the sign extension of the source
    always_ff @(posedge Clk)
    begin
        if (reset || latchInt)
            OP2 <= Vector[wordWidth-1:dataWidth];
        else if (ceOp2)
            OP2 <= signFill ? {dataWidth{opDi[dataWidth-1]}} : opDi;
    end

endmodule

`default_nettype wire

//--- src/dataOutMux.sv
////////////////////////////////////////////////////////////////////////////
// Outgoing data byte for pushes and stores. OR of every selected source
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module dataOutMux
    import coreFrontEndPkg::*;
(
    input  dataOpU               dataOp,   // Read through doView here
    input  modeT                 Mode,
    input  logic [dataWidth-1:0] OP1,
    input  logic [dataWidth-1:0] OP2,
    input  logic [dataWidth-1:0] aluDo,
    input  logic [dataWidth-1:0] P,
    input  logic [wordWidth-1:0] MAR,
    input  logic [wordWidth-1:0] PC,
    output logic [dataWidth-1:0] DO
);

    logic [wordWidth-1:0] wordSrc;

    // Word pushed by PHW, PHR or a return address push
    always_comb
    begin
        if (Mode == modePhw)
            wordSrc = {OP2, OP1};
        else if (Mode == modePhr)
            wordSrc = MAR;
        else
            wordSrc = PC;
    end

    // Selects are not exclusive, sources combine bitwise
    assign DO = ({dataWidth{dataOp.doView.selAlu}} & aluDo)
              | ({dataWidth{dataOp.doView.selHi}}  & wordSrc[wordWidth-1:dataWidth])
              | ({dataWidth{dataOp.doView.selLo}}  & wordSrc[dataWidth-1:0])
              | ({dataWidth{dataOp.doView.selP}}   & P);

endmodule

`default_nettype wire

//--- src/coreFrontEnd.sv
////////////////////////////////////////////////////////////////////////////
// Operand and instruction capture front end of the processor core.
// Microword and via come from an external sequencer, ALU and address
// results come in as plain inputs
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module coreFrontEnd
    import coreFrontEndPkg::*;
(
    input  logic                 Clk,
    input  logic                 reset,

    // Sequencer side
    input  uWordT                uWord,
    input  logic [1:0]           via,

    // Memory, interrupt and ALU side
    input  logic [dataWidth-1:0] DI,
    input  logic                 Wait,
    input  logic                 Int,
    input  logic                 Valid,
    input  logic [wordWidth-1:0] Vector,
    input  logic [wordWidth-1:0] MAR,
    input  logic [wordWidth-1:0] PC,
    input  logic [dataWidth-1:0] aluDo,
    input  logic [dataWidth-1:0] P,

    // Status
    output logic                 Done,
    output logic                 SC,
    output logic                 Rdy,
    output logic                 LE_Int,
    output logic                 VP,

    // Captured instruction and operands
    output logic [dataWidth-1:0] IR,
    output logic [dataWidth-1:0] OP1,
    output logic [dataWidth-1:0] OP2,
    output modeT                 Mode,
    output logic                 IND,
    output logic                 SIZ,
    output logic                 OAX,
    output logic                 OAY,
    output logic [dataWidth-1:0] DO
);

    uWordT                uPl;                  // Registered microword
    logic                 ceIr;
    logic                 ceOp1;
    logic                 ceOp2;
    logic                 selBa;
    logic                 latchInt;
    logic [dataWidth-1:0] opDi;                 // Operand source byte

    ////////////////////////////////////////////////////////////////////////////
    // Shared steering

    assign selBa    = (uPl.uCntl == uCntlSelBa);
    assign opDi     = selBa ? uPl.branchField : DI;   // Immediate from microcode
    assign latchInt = (via == viaLatchInt);

    microwordLatch i_microwordLatch (
        .Clk   (Clk),
        .reset (reset),
        .Rdy   (Rdy),
        .uWord (uWord),
        .uPl   (uPl)
    );

    cycleControl i_cycleControl (
        .Clk    (Clk),
        .reset  (reset),
        .uPl    (uPl),
        .via    (via),
        .Wait   (Wait),
        .Int    (Int),
        .Valid  (Valid),
        .Done   (Done),
        .SC     (SC),
        .Rdy    (Rdy),
        .LE_Int (LE_Int),
        .VP     (VP),
        .ceIr   (ceIr),
        .ceOp1  (ceOp1),
        .ceOp2  (ceOp2)
    );

    instrRegister i_instrRegister (
        .Clk         (Clk),
        .reset       (reset),
        .ceIr        (ceIr),
        .latchInt    (latchInt),
        .selBa       (selBa),
        .branchField (uPl.branchField),
        .DI          (DI),
        .IR          (IR),
        .Mode        (Mode),
        .IND         (IND),
        .SIZ         (SIZ),
        .OAX         (OAX),
        .OAY         (OAY)
    );

    operandRegisters i_operandRegisters (
        .Clk      (Clk),
        .reset    (reset),
        .latchInt (latchInt),
        .ceOp1    (ceOp1),
        .ceOp2    (ceOp2),
        .signFill (uPl.dataOp.diView.signFill),
        .opDi     (opDi),
        .Vector   (Vector),
        .OP1      (OP1),
        .OP2      (OP2)
    );

    // Same dataOp bits, read as output selects
    dataOutMux i_dataOutMux (
        .dataOp (uPl.dataOp),
        .Mode   (Mode),
        .OP1    (OP1),
        .OP2    (OP2),
        .aluDo  (aluDo),
        .P      (P),
        .MAR    (MAR),
        .PC     (PC),
        .DO     (DO)
    );

endmodule

`default_nettype wire

//--- sim/coreFrontEnd_properties.sv
////////////////////////////////////////////////////////////////////////////
// Concurrent checks on status strobes, ready and reset state. Bound into
// every coreFrontEnd instance
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module coreFrontEnd_properties
    import coreFrontEndPkg::*;
(
    input logic                 Clk,
    input logic                 reset,
    input logic [1:0]           via,
    input logic                 LE_Int,
    input logic                 SC,
    input logic                 Done,
    input logic                 Wait,
    input logic                 Rdy,
    input logic                 VP,
    input logic [dataWidth-1:0] IR
);

    // Latch strobe is a plain decode of via 10
    leIntDecode: assert property (@(posedge Clk) LE_Int == (via == viaLatchInt))
        else $error("LE_Int does not follow via code 10");

    scImpliesDone: assert property (@(posedge Clk) SC |-> Done)
        else $error("SC high without Done");

    // External wait always stalls
    waitStalls: assert property (@(posedge Clk) Wait |-> !Rdy)
        else $error("Rdy high while Wait is high");

    resetState: assert property (@(posedge Clk) reset |=> (IR == opNop) && !VP)
        else $error("IR or VP wrong one cycle after reset");

endmodule

bind coreFrontEnd coreFrontEnd_properties i_coreFrontEndProperties (
    .Clk    (Clk),
    .reset  (reset),
    .via    (via),
    .LE_Int (LE_Int),
    .SC     (SC),
    .Done   (Done),
    .Wait   (Wait),
    .Rdy    (Rdy),
    .VP     (VP),
    .IR     (IR)
);

`default_nettype wire

//--- sim/coreFrontEndTb.sv
////////////////////////////////////////////////////////////////////////////
// Directed testbench for the core front end. Drives microwords and via
// codes by hand and checks IR, operands, prefixes, DO, Rdy and VP
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module coreFrontEndTb
    import coreFrontEndPkg::*;
();

    localparam int cycleLimit = 600;     // Tests need about 100 cycles

    logic                 Clk = 1'b0;
    logic                 reset;
    uWordT                uWord;
    logic [1:0]           via;
    logic [dataWidth-1:0] DI, aluDo, P;
    logic                 Wait, Int, Valid;
    logic [wordWidth-1:0] Vector, MAR, PC;
    logic                 Done, SC, Rdy, LE_Int, VP;
    logic [dataWidth-1:0] IR, OP1, OP2, DO;
    modeT                 Mode;
    logic                 IND, SIZ, OAX, OAY;

    int                   errorCount = 0;
    int                   cycleCount = 0;
    logic [31:0]          rngState;
    logic [7:0]           opLowExp;      // Expected OP1
    logic [7:0]           opHighExp;     // Expected OP2
    logic [15:0]          vecInit;

    coreFrontEnd i_coreFrontEnd (
        .Clk(Clk), .reset(reset), .uWord(uWord), .via(via), .DI(DI),
        .Wait(Wait), .Int(Int), .Valid(Valid), .Vector(Vector), .MAR(MAR),
        .PC(PC), .aluDo(aluDo), .P(P), .Done(Done), .SC(SC), .Rdy(Rdy),
        .LE_Int(LE_Int), .VP(VP), .IR(IR), .OP1(OP1), .OP2(OP2), .Mode(Mode),
        .IND(IND), .SIZ(SIZ), .OAX(OAX), .OAY(OAY), .DO(DO)
    );

    always #50 Clk = ~Clk;               // 100 ns period

    // Run limit
    always @(posedge Clk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit)
        begin
            $display("Timeout after %0d cycles, the tests did not finish", cycleCount);
            $display("Checks done, %0d errors", errorCount);
            $display("test failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [7:0] randomByte();
        rngState = xorshift32(rngState);
        return rngState[7:0];
    endfunction

    // Random opcode that is no prefix, NOP, WAI, PHW or PHR
    function automatic logic [7:0] randomPlainOp();
        logic [7:0] op;
        op = randomByte();
        if (op[3:0] == 4'hB)
            op[3:0] = 4'hA;
        if ((op == opPhw) || (op == opPhr) || (op == opNop))
            op = op ^ 8'h01;
        return op;
    endfunction

    task automatic checkValue(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
        if (got !== exp)
        begin
            errorCount++;
            $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    // Word is in uPl at the returned negedge
    task automatic applyWord(input uWordT w);
        @(posedge Clk);
        uWord <= w;
        @(posedge Clk);
        @(negedge Clk);
    endtask

    // Via 01 fetch of one opcode from DI
    task automatic fetchOpcode(input logic [7:0] op);
        @(posedge Clk);
        via <= viaFetch1;
        DI  <= op;
        @(posedge Clk);
        via <= 2'b00;
        @(negedge Clk);
        checkValue("IR", 16'(IR), 16'(op));
    endtask

    task automatic checkPrefixes(input logic ind, input logic siz,
                                 input logic oax, input logic oay);
        checkValue("IND", 16'(IND), 16'(ind));
        checkValue("SIZ", 16'(SIZ), 16'(siz));
        checkValue("OAX", 16'(OAX), 16'(oax));
        checkValue("OAY", 16'(OAY), 16'(oay));
    endtask

    // Operand word held long enough for one load, then cleared
    task automatic runOperandWord(input uWordT w, input logic [7:0] din);
        @(posedge Clk);
        uWord <= w;
        DI    <= din;
        @(posedge Clk);
        @(posedge Clk);
        uWord <= '0;
        @(negedge Clk);
        checkValue("OP1", 16'(OP1), 16'(opLowExp));
        checkValue("OP2", 16'(OP2), 16'(opHighExp));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests

    task automatic testResetState(input logic [15:0] vec);
        logic [15:0] vecNew;
        @(negedge Clk);
        checkValue("IR", 16'(IR), 16'(opNop));
        opLowExp  = vec[7:0];
        opHighExp = vec[15:8];
        checkValue("OP1", 16'(OP1), 16'(opLowExp));
        checkValue("OP2", 16'(OP2), 16'(opHighExp));
        checkPrefixes(1'b0, 1'b0, 1'b0, 1'b0);
        checkValue("VP", 16'(VP), 16'h0);
        checkValue("Done", 16'(Done), 16'h0);
        checkValue("SC", 16'(SC), 16'h0);
        checkValue("LE_Int", 16'(LE_Int), 16'h0);
        fetchOpcode(randomPlainOp());        // Move IR off NOP
        vecNew = {randomByte(), randomByte()};
        @(posedge Clk);
        via    <= viaLatchInt;               // Interrupt latch under wait
        Wait   <= 1'b1;
        Vector <= vecNew;
        @(negedge Clk);
        checkValue("LE_Int", 16'(LE_Int), 16'h1);
        checkValue("Rdy", 16'(Rdy), 16'h0);
        @(posedge Clk);
        via  <= 2'b00;
        Wait <= 1'b0;
        @(negedge Clk);
        opLowExp  = vecNew[7:0];
        opHighExp = vecNew[15:8];
        checkValue("IR", 16'(IR), 16'(opNop));
        checkValue("OP1", 16'(OP1), 16'(opLowExp));
        checkValue("OP2", 16'(OP2), 16'(opHighExp));
    endtask

    task automatic testOpcodeFetch;
        logic [7:0] op;
        op = randomByte();
        fetchOpcode(op);
        @(posedge Clk);
        via <= viaFetch3;                    // Int pending, no fetch
        Int <= 1'b1;
        DI  <= ~op;
        @(negedge Clk);
        checkValue("SC", 16'(SC), 16'h1);
        checkValue("Done", 16'(Done), 16'h1);
        @(posedge Clk);
        via <= 2'b00;
        Int <= 1'b0;
        @(negedge Clk);
        checkValue("IR", 16'(IR), 16'(op));
        @(posedge Clk);
        via  <= viaFetch1;                   // Stalled fetch
        Wait <= 1'b1;
        @(negedge Clk);
        checkValue("Rdy", 16'(Rdy), 16'h0);
        @(posedge Clk);
        via  <= 2'b00;
        Wait <= 1'b0;
        @(negedge Clk);
        checkValue("IR", 16'(IR), 16'(op));
        fetchOpcode(opWai);
        checkValue("Mode", 16'(Mode), 16'(modeWai));
    endtask

    task automatic testPrefixes;
        fetchOpcode(randomPlainOp());        // Clear any chain from earlier
        fetchOpcode(8'hAB);
        checkValue("Mode", 16'(Mode), 16'(modePfx));
        checkPrefixes(1'b0, 1'b0, 1'b0, 1'b0);
        fetchOpcode(8'hBB);
        checkPrefixes(1'b0, 1'b1, 1'b0, 1'b0);
        fetchOpcode(8'h9B);
        checkPrefixes(1'b1, 1'b1, 1'b0, 1'b0);
        fetchOpcode(randomPlainOp());
        checkValue("Mode", 16'(Mode), 16'(modeVal));
        checkPrefixes(1'b1, 1'b1, 1'b1, 1'b0);
        fetchOpcode(randomPlainOp());
        checkPrefixes(1'b0, 1'b0, 1'b0, 1'b0);
        fetchOpcode(8'h8B);                  // Y destination override
        checkPrefixes(1'b0, 1'b0, 1'b0, 1'b0);
        fetchOpcode(randomPlainOp());
        checkPrefixes(1'b0, 1'b0, 1'b0, 1'b1);
    endtask

    task automatic testOperandCapture;
        uWordT      w;
        logic [7:0] din;
        w = '0;
        w.ioOp[ioRead] = 1'b1;
        w.dataOp.diView.ldOp1 = 1'b1;
        din = randomByte();
        opLowExp = din;
        runOperandWord(w, din);
        w.dataOp.diView.ldOp1    = 1'b0;
        w.dataOp.diView.ldOp2    = 1'b1;
        w.dataOp.diView.signFill = 1'b1;
        din = randomByte() & 8'h7F;          // Positive source byte
        opHighExp = {8{din[7]}};
        runOperandWord(w, din);
        din = randomByte() | 8'h80;          // Negative source byte
        opHighExp = {8{din[7]}};
        runOperandWord(w, din);
        w = '0;
        w.ioOp[ioRead] = 1'b1;
        w.dataOp.diView.ldOp1 = 1'b1;
        w.uCntl = 2'b01;                     // Immediate from branch field
        w.branchField = randomByte();
        opLowExp = w.branchField;
        runOperandWord(w, ~w.branchField);
    endtask

    task automatic testDataOut;
        uWordT       wHi, wLo, wMix;
        logic [15:0] marVal, pcVal;
        logic [7:0]  aluVal, pVal;
        marVal = {randomByte(), randomByte()};
        pcVal  = {randomByte(), randomByte()};
        aluVal = randomByte();
        pVal   = randomByte();
        @(posedge Clk);
        MAR   <= marVal;
        PC    <= pcVal;
        aluDo <= aluVal;
        P     <= pVal;
        wHi = '0;
        wHi.dataOp.doView.selHi = 1'b1;
        wLo = '0;
        wLo.dataOp.doView.selLo = 1'b1;
        wMix = '0;
        wMix.dataOp.doView.selAlu = 1'b1;
        wMix.dataOp.doView.selP   = 1'b1;
        fetchOpcode(opPhw);
        checkValue("Mode", 16'(Mode), 16'(modePhw));
        applyWord(wHi);
        checkValue("DO", 16'(DO), 16'(opHighExp));
        applyWord(wLo);
        checkValue("DO", 16'(DO), 16'(opLowExp));
        fetchOpcode(opPhr);
        checkValue("Mode", 16'(Mode), 16'(modePhr));
        applyWord(wHi);
        checkValue("DO", 16'(DO), 16'(marVal[15:8]));
        applyWord(wLo);
        checkValue("DO", 16'(DO), 16'(marVal[7:0]));
        fetchOpcode(randomPlainOp());
        applyWord(wHi);
        checkValue("DO", 16'(DO), 16'(pcVal[15:8]));
        applyWord(wLo);
        checkValue("DO", 16'(DO), 16'(pcVal[7:0]));
        applyWord(wMix);
        checkValue("DO", 16'(DO), 16'(aluVal | pVal));
        applyWord('0);
    endtask

    task automatic testReadyAndVp;
        uWordT      w;
        logic [1:0] v;
        logic       expRdy;
        for (int r = 0; r < 2; r++)
        begin
            w = '0;
            w.regWe = (r == 1) ? 3'b100 : 3'b000;
            applyWord(w);
            for (int k = 0; k < 8; k++)
            begin
                v = k[2] ? viaFetch3 : 2'b00;
                @(posedge Clk);
                via   <= v;
                Int   <= 1'b1;                // Keeps via 11 from fetching
                Valid <= k[1];
                Wait  <= k[0];
                @(negedge Clk);
                expRdy = !k[0] && !((v != 2'b00) && (r == 1) && !k[1]);
                checkValue("Rdy", 16'(Rdy), 16'(expRdy));
            end
            @(posedge Clk);
            via   <= 2'b00;
            Int   <= 1'b0;
            Valid <= 1'b0;
            Wait  <= 1'b0;
        end
        w = '0;
        w.isr   = 1'b1;
        w.uCntl = 2'b01;                     // Vector pull starts
        applyWord(w);
        @(negedge Clk);
        checkValue("VP", 16'(VP), 16'(w.uCntl[0]));
        w.uCntl = 2'b10;                     // Vector pull ends
        applyWord(w);
        @(negedge Clk);
        checkValue("VP", 16'(VP), 16'(w.uCntl[0]));
        applyWord('0);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence

    initial
    begin
        rngState = 32'h2ccf_6fbe;
        vecInit  = {randomByte(), randomByte()};
        reset  <= 1'b1;
        uWord  <= '0;                        // Zero word loaded during reset
        via    <= 2'b00;
        DI     <= '0;
        Wait   <= 1'b0;
        Int    <= 1'b0;
        Valid  <= 1'b0;
        Vector <= vecInit;
        MAR    <= '0;
        PC     <= '0;
        aluDo  <= '0;
        P      <= '0;
        repeat (2) @(posedge Clk);
        reset <= 1'b0;
        testResetState(vecInit);
        testOpcodeFetch();
        testPrefixes();
        testOperandCapture();
        testDataOut();
        testReadyAndVp();
        $display("Checks done, %0d errors", errorCount);
        if (errorCount == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- coreFrontEnd.f
src/coreFrontEndPkg.sv
src/microwordLatch.sv
src/cycleControl.sv
src/instrRegister.sv
src/operandRegisters.sv
src/dataOutMux.sv
src/coreFrontEnd.sv
sim/coreFrontEnd_properties.sv
sim/coreFrontEndTb.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f coreFrontEnd.f \
    --top-module coreFrontEndTb -o simCoreFrontEnd
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/simCoreFrontEnd)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "test passed"; then
    exit 0
else
    exit 1
fi
